// File: include/tg_defines.svh
`ifndef TG_DEFINES_SVH
`define TG_DEFINES_SVH

// widths
`define TG_CYC_W            13      // output cycle number, bootloop count fits
`define TG_ABS_W            12      // absolute position 0..2052
`define TG_RCNT_W           10      // rotation counter, up to 568

// 48 MHz phases per 4 MHz period, minus one
`define TG_PHASE_LAST       11

// rotation counter points, in MCLK counts from start
`define TG_RCNT_LOOP        89      // value after +Y, closes the 480 clk loop
`define TG_RCNT_STOP_CHK    208     // -X position, field may stop here
`define TG_RCNT_MINUS_Y     326     // -Y, launched two counts early for buffer delay
`define TG_RCNT_PLUS_Y      568     // +Y, one bubble position per pass

// absolute position of the loops
`define TG_ABS_INIT         1951
`define TG_ABS_LAST         2052    // 2053 positions per minor loop

// output cycle counting
`define TG_DELAY_LAST       97      // 98 positions from replicators to detector
`define TG_PAGE_LAST        583     // 584 bits per page
`define TG_BOOT_LAST        4105    // two bootloops of 2053
`define TG_NUM_NONE         8191    // empty propagation line

`endif

// File: rtl/tg_pkg.sv
`include "tg_defines.svh"

package tg_pkg;

    // access state
    // bit 2: field rotates
    // bit 1: data goes out
    // bit 0: page, not bootloop
    typedef enum logic [2:0] {
        RST  = 3'b000,      // reset, field stopped
        STBY = 3'b001,      // standby, waiting for bsen_n
        BOOT = 3'b110,      // bootloop read
        USER = 3'b111,      // page read, replicator fired
        IDLE = 3'b100       // seeking, field rotates without data
    } access_t;

    // controller strobes, all active low
    // bit order follows the decode table in access_decode
    typedef struct packed {
        logic bss_n;        // shift start
        logic booten_n;     // bootloop enable
        logic bsen_n;       // shift enable, field rotates while low
        logic repen_n;      // replicator enable
    } bubble_ctrl_t;

    // field position flags from the rotation counter
    typedef struct packed {
        logic halted;       // counter at zero, no field
        logic plus_y;       // +Y point, one clk
        logic minus_y;      // -Y point, one clk
    } field_pos_t;

    // data output side
    typedef struct packed {
        logic [`TG_CYC_W-1:0] cycle_num;   // all ones when nothing valid
        logic                 clken_n;     // launch strobe for the data
    } bout_t;

endpackage

// File: rtl/clock_phase_gen.sv
`timescale 1ns/1ps
`include "tg_defines.svh"

module clock_phase_gen
(
    input  logic MCLK,
    input  logic rst_n,
    output logic clk4m,         // controller clock, MCLK/12
    output logic sample_stb     // strobe capture, three per 4 MHz period
);

    localparam int PH_W = $clog2(`TG_PHASE_LAST + 1);
    localparam logic [PH_W-1:0] PH_LAST = PH_W'(`TG_PHASE_LAST);
    localparam logic [PH_W-1:0] PH_HALF = PH_W'(`TG_PHASE_LAST / 2);  // 5

    logic [PH_W-1:0] phase;

    // 0..11, reset to the middle so clk4m starts a plain high half
    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase <= PH_HALF + 1'b1;
            clk4m <= 1'b1;
        end
        else
        begin
            if (phase == PH_LAST)
            begin
                phase <= '0;
                clk4m <= 1'b0;      // controller launches on this edge
            end
            else
            begin
                phase <= phase + 1'b1;
                if (phase == PH_HALF)
                    clk4m <= 1'b1;
            end
        end
    end

    // just before each 12 MHz falling edge
    // strobes from the controller are stable by then
    assign sample_stb = (phase == PH_W'(3)) || (phase == PH_W'(7)) || (phase == PH_LAST);

endmodule

// File: rtl/access_decode.sv
`timescale 1ns/1ps

module access_decode
    import tg_pkg::*;
(
    input  logic         MCLK,
    input  logic         rst_n,
    input  logic         en_n,          // emulator disabled when high
    input  bubble_ctrl_t ctrl_in,       // async to MCLK
    input  logic         sample_stb,
    output access_t      acc_type
);

    // what the decoder sees with the emulator off
    localparam bubble_ctrl_t CTRL_RST = '{bss_n: 1'b1, booten_n: 1'b0,
                                          bsen_n: 1'b1, repen_n: 1'b1};

    bubble_ctrl_t ctrl_gated;
    bubble_ctrl_t sync1;
    bubble_ctrl_t sync2;
    bubble_ctrl_t ctrl_smp;     // pattern at the last sample point
    access_t      acc_nxt;

    // en_n high forces the reset pattern
    // repen_n is ignored while bootloops are selected
    assign ctrl_gated = '{bss_n:    en_n | ctrl_in.bss_n,
                          booten_n: ~en_n & ctrl_in.booten_n,
                          bsen_n:   en_n | ctrl_in.bsen_n,
                          repen_n:  en_n | ctrl_in.repen_n | ~ctrl_in.booten_n};

    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync1    <= CTRL_RST;
            sync2    <= CTRL_RST;
            ctrl_smp <= CTRL_RST;
        end
        else
        begin
            sync1 <= ctrl_gated;        // two flop sync
            sync2 <= sync1;
            if (sample_stb)
                ctrl_smp <= sync2;
        end
    end

    // pattern order: bss_n booten_n bsen_n repen_n
    always_comb
    begin
        acc_nxt = acc_type;     // anything unlisted holds
        case (ctrl_smp)
            4'b0011, 4'b0111:   // shift start pulse
            begin
                if (acc_type == RST)
                    acc_nxt = STBY;
            end
            4'b1011, 4'b1111:   // quiet, bootloop or user side
            begin
                if (acc_type != STBY)
                    acc_nxt = RST;
            end
            4'b1001:            // bootloop read running
            begin
                if (acc_type == STBY || acc_type == RST || acc_type == BOOT)
                    acc_nxt = BOOT;
            end
            4'b1101:            // page seek, field on
            begin
                if (acc_type == STBY || acc_type == RST)
                    acc_nxt = IDLE;
            end
            4'b1100:            // replicate pulse
            begin
                if (acc_type == IDLE)
                    acc_nxt = USER;
            end
            default:
            begin
                acc_nxt = acc_type;
            end
        endcase
    end

    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
            acc_type <= RST;
        else
            acc_type <= acc_nxt;
    end

endmodule

// File: rtl/field_rotation.sv
`timescale 1ns/1ps
`include "tg_defines.svh"

module field_rotation
    import tg_pkg::*;
(
    input  logic                 MCLK,
    input  logic                 rst_n,
    input  access_t              acc_type,
    output field_pos_t           pos,
    output logic [`TG_ABS_W-1:0] abspos     // position under the detector
);

    localparam logic [`TG_RCNT_W-1:0] R_LOOP  = `TG_RCNT_W'(`TG_RCNT_LOOP);
    localparam logic [`TG_RCNT_W-1:0] R_STOP  = `TG_RCNT_W'(`TG_RCNT_STOP_CHK);
    localparam logic [`TG_RCNT_W-1:0] R_MINUS = `TG_RCNT_W'(`TG_RCNT_MINUS_Y);
    localparam logic [`TG_RCNT_W-1:0] R_PLUS  = `TG_RCNT_W'(`TG_RCNT_PLUS_Y);

    logic [`TG_RCNT_W-1:0] rcnt;       // counts from 1, 0 means stopped
    logic [`TG_RCNT_W-1:0] rcnt_nxt;

    always_comb
    begin
        if (rcnt == '0)
            rcnt_nxt = acc_type[2] ? `TG_RCNT_W'(1) : '0;   // wait for rotation
        else if (rcnt == R_STOP && !acc_type[2])
            rcnt_nxt = '0;                  // field stops only at -X
        else if (rcnt == R_PLUS)
            rcnt_nxt = R_LOOP;              // 480 clk per bubble cycle
        else
            rcnt_nxt = rcnt + 1'b1;
    end

    // flags decoded from the next count, so they line up with rcnt
    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rcnt        <= '0;
            pos.halted  <= 1'b1;
            pos.plus_y  <= 1'b0;
            pos.minus_y <= 1'b0;
        end
        else
        begin
            rcnt        <= rcnt_nxt;
            pos.halted  <= (rcnt_nxt == '0);
            pos.plus_y  <= (rcnt_nxt == R_PLUS);
            pos.minus_y <= (rcnt_nxt == R_MINUS);
        end
    end

    // one position per +Y
    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
            abspos <= `TG_ABS_W'(`TG_ABS_INIT);
        else if (pos.plus_y)
        begin
            if (abspos == `TG_ABS_W'(`TG_ABS_LAST))
                abspos <= '0;
            else
                abspos <= abspos + 1'b1;
        end
    end

endmodule

// File: rtl/bout_cycle_result.sv
`timescale 1ns/1ps
`include "tg_defines.svh"

module bout_cycle_result
    import tg_pkg::*;
(
    input  logic       MCLK,
    input  logic       rst_n,
    input  access_t    acc_type,
    input  field_pos_t pos,
    output bout_t      bout
);

    // all ones is the idle value of both counters, above any valid count
    localparam int DLY_W  = $clog2(`TG_DELAY_LAST + 2);    // 7
    localparam int PAGE_W = $clog2(`TG_PAGE_LAST + 2);     // 10

    localparam logic [DLY_W-1:0]     DLY_LAST  = DLY_W'(`TG_DELAY_LAST);
    localparam logic [PAGE_W-1:0]    PAGE_LAST = PAGE_W'(`TG_PAGE_LAST);
    localparam logic [`TG_CYC_W-1:0] BOOT_LAST = `TG_CYC_W'(`TG_BOOT_LAST);
    localparam logic [`TG_CYC_W-1:0] NUM_NONE  = `TG_CYC_W'(`TG_NUM_NONE);

    logic [DLY_W-1:0]     dly_cnt;      // replicator to detector travel
    logic [PAGE_W-1:0]    page_cnt;     // bit within the page
    logic [`TG_CYC_W-1:0] boot_cnt;     // follows the loops, never cleared
    logic [`TG_CYC_W-1:0] boot_nxt;
    logic [PAGE_W-1:0]    page_nxt;
    logic [`TG_CYC_W-1:0] cycle_num;
    logic                 clken_n;

    always_comb
    begin
        if (boot_cnt == BOOT_LAST)
            boot_nxt = '0;
        else
            boot_nxt = boot_cnt + 1'b1;
        page_nxt = page_cnt + 1'b1;     // 1023 rolls to 0 on the first bit
    end

    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dly_cnt   <= '1;
            page_cnt  <= '1;
            boot_cnt  <= `TG_CYC_W'(`TG_ABS_INIT);
            cycle_num <= NUM_NONE;
        end
        else if (pos.halted)
        begin
            if (acc_type == RST)        // stopped and reset, ready for next read
            begin
                dly_cnt   <= '1;
                page_cnt  <= '1;
                cycle_num <= NUM_NONE;
            end
        end
        else if (pos.plus_y)
        begin
            boot_cnt <= boot_nxt;       // loops move whatever the state
            if (!acc_type[1])
            begin
                // field on, nothing read out
                dly_cnt   <= '1;
                page_cnt  <= '1;
                cycle_num <= NUM_NONE;
            end
            else if (dly_cnt == '1 || dly_cnt < DLY_LAST)
            begin
                // line still empty, 98 ticks
                dly_cnt   <= dly_cnt + 1'b1;
                page_cnt  <= '1;
                cycle_num <= NUM_NONE;
            end
            else if (!acc_type[0])
            begin
                page_cnt  <= '1;
                cycle_num <= boot_nxt;  // bootloop bit now at the detector
            end
            else if (page_cnt == '1 || page_cnt < PAGE_LAST)
            begin
                page_cnt  <= page_nxt;
                cycle_num <= `TG_CYC_W'(page_nxt);
            end
            // else last page bit, hold everything
        end
    end

    // one clk low, from -Y
    always_ff @(posedge MCLK or negedge rst_n)
    begin
        if (!rst_n)
            clken_n <= 1'b1;
        else
            clken_n <= ~pos.minus_y;
    end

    assign bout = '{cycle_num: cycle_num, clken_n: clken_n};

endmodule

// File: rtl/timing_generator.sv
`timescale 1ns/1ps
`include "tg_defines.svh"

module timing_generator
    import tg_pkg::*;
(
    input  logic                 MCLK,          // 48 MHz
    input  logic                 rst_n,
    input  logic                 en_n,
    input  bubble_ctrl_t         ctrl_in,
    output logic                 clk4m,
    output access_t              acc_type,
    output logic [`TG_ABS_W-1:0] abspos,
    output bout_t                bout
);

    logic       sample_stb;
    field_pos_t pos;

    clock_phase_gen u_phase (
        .MCLK       (MCLK),
        .rst_n      (rst_n),
        .clk4m      (clk4m),
        .sample_stb (sample_stb)
    );

    access_decode u_access (
        .MCLK       (MCLK),
        .rst_n      (rst_n),
        .en_n       (en_n),
        .ctrl_in    (ctrl_in),
        .sample_stb (sample_stb),
        .acc_type   (acc_type)
    );

    field_rotation u_field (
        .MCLK     (MCLK),
        .rst_n    (rst_n),
        .acc_type (acc_type),
        .pos      (pos),
        .abspos   (abspos)
    );

    bout_cycle_result u_bout (
        .MCLK     (MCLK),
        .rst_n    (rst_n),
        .acc_type (acc_type),
        .pos      (pos),
        .bout     (bout)
    );

endmodule

// File: tests/tg_props.sv
`timescale 1ns/1ps
`include "tg_defines.svh"

module tg_props
    import tg_pkg::*;
(
    input logic       MCLK,
    input logic       rst_n,
    input access_t    acc_type,
    input field_pos_t pos,
    input bout_t      bout
);

    localparam logic [`TG_CYC_W-1:0] PAGE_LAST = `TG_CYC_W'(`TG_PAGE_LAST);
    localparam logic [`TG_CYC_W-1:0] NUM_NONE  = `TG_CYC_W'(`TG_NUM_NONE);

    // launch strobe is one clk wide
    clken_single: assert property (@(posedge MCLK) disable iff (!rst_n)
        !bout.clken_n |=> bout.clken_n)
        else $error("clken_n low for two cycles");

    // page reads never show a bit past the end of the page
    page_range: assert property (@(posedge MCLK) disable iff (!rst_n)
        acc_type == USER |-> (bout.cycle_num <= PAGE_LAST || bout.cycle_num == NUM_NONE))
        else $error("cycle_num outside the page during USER");

    // +Y moves the number, a stopped field in RST clears it
    num_on_tick: assert property (@(posedge MCLK) disable iff (!rst_n)
        bout.cycle_num != $past(bout.cycle_num) |-> ($past(pos.plus_y) || $past(pos.halted)))
        else $error("cycle_num changed away from a +Y tick");

endmodule

bind bout_cycle_result tg_props u_props (
    .MCLK     (MCLK),
    .rst_n    (rst_n),
    .acc_type (acc_type),
    .pos      (pos),
    .bout     (bout)
);

// File: tests/tb_timing_generator.sv
`timescale 1ns/1ps
`include "tg_defines.svh"

module tb_timing_generator
    import tg_pkg::*;
();

    localparam int BUBBLE = 480;                                // MCLK per bubble cycle
    localparam int LIMIT  = (700 + 400 + 20) * BUBBLE + 2000;
    localparam int NSTEP  = 11;

    typedef struct packed {
        logic         en_n;
        bubble_ctrl_t ctrl;     // bss_n booten_n bsen_n repen_n
        access_t      exp;
    } step_t;

    step_t steps [NSTEP] = '{
        '{1'b0, 4'b1011, RST},      // quiet, stays in reset
        '{1'b0, 4'b0011, STBY},     // shift start
        '{1'b0, 4'b1011, STBY},     // quiet holds standby
        '{1'b0, 4'b1001, BOOT},
        '{1'b0, 4'b1011, RST},      // bootloop done
        '{1'b0, 4'b0111, STBY},
        '{1'b0, 4'b0000, STBY},     // illegal, no change
        '{1'b0, 4'b1101, IDLE},
        '{1'b0, 4'b1100, USER},     // replicate
        '{1'b0, 4'b1101, USER},     // no way back to seek
        '{1'b1, 4'b1100, RST}       // emulator disabled
    };

    logic                 MCLK;
    logic                 rst_n;
    logic                 en_n;
    bubble_ctrl_t         ctrl_in;
    logic                 clk4m;
    access_t              acc_type;
    logic [`TG_ABS_W-1:0] abspos;
    bout_t                bout;
    integer               seed = 32'h72e4;   // $random seed
    int                   cycles = 0;
    int                   val_errs = 0;      // wrong values
    int                   other_errs = 0;    // missing or stray events
    int                   prev_at;           // last clken_n pulse
    logic [`TG_ABS_W-1:0] prev_pos;
    logic                 have_prev;

    timing_generator uut (.MCLK(MCLK), .rst_n(rst_n), .en_n(en_n), .ctrl_in(ctrl_in),
                          .clk4m(clk4m), .acc_type(acc_type), .abspos(abspos), .bout(bout));

    initial
    begin
        MCLK = 1'b0;
        forever #5 MCLK = ~MCLK;
    end

    always @(posedge MCLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT)
        begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Error: %s = %h, expected %h at cycle %0d", name, got, exp, cycles);
            val_errs++;
        end
    endtask

    // drive a pattern, give the decoder up to 20 clks
    task automatic set_ctrl(input logic en, input bubble_ctrl_t ctrl, input access_t exp);
        int n;
        begin
            @(posedge MCLK);
            en_n    <= en;
            ctrl_in <= ctrl;
            n = 0;
            @(negedge MCLK);
            while (acc_type != exp && n < 20)
            begin
                @(negedge MCLK);
                n++;
            end
            check_val("acc_type", acc_type, exp);
        end
    endtask

    // next clken_n pulse, checks spacing and position step against the last one
    task automatic take_pulse(output logic [`TG_CYC_W-1:0] num);
        int start;
        begin
            start = cycles;
            @(negedge MCLK);
            while (bout.clken_n && cycles - start < 2 * BUBBLE)
                @(negedge MCLK);
            if (bout.clken_n)
            begin
                $display("no clken_n pulse for %0d cycles", 2 * BUBBLE);
                other_errs++;
            end
            if (have_prev)
            begin
                check_val("clken_n gap", cycles - prev_at, BUBBLE);
                check_val("abspos", abspos, (prev_pos == `TG_ABS_LAST) ? 0 : prev_pos + 1);
            end
            num       = bout.cycle_num;
            prev_at   = cycles;
            prev_pos  = abspos;
            have_prev = 1'b1;
        end
    endtask

    // skip the empty propagation line, return the first real number
    task automatic skip_empty(output logic [`TG_CYC_W-1:0] num);
        int n;
        begin
            n = 0;
            take_pulse(num);
            while (num == `TG_NUM_NONE && n < 200)
            begin
                n++;
                take_pulse(num);
            end
            if (n < 98 || n > 99)
            begin
                $display("%0d empty cycles before data, 98 or 99 expected", n);
                other_errs++;
            end
        end
    endtask

    initial
    begin
        logic [`TG_CYC_W-1:0] num;
        logic [`TG_CYC_W-1:0] exp_num;
        logic [`TG_ABS_W-1:0] pos0;
        logic                 clk_prev;
        int                   last_chg;
        int                   n_chg;
        int                   stray;
        rst_n     = 1'b0;
        en_n      = 1'b0;
        ctrl_in   = 4'b1011;
        have_prev = 1'b0;
        repeat (4) @(posedge MCLK);
        rst_n <= 1'b1;

        @(negedge MCLK);
        check_val("acc_type", acc_type, RST);
        check_val("cycle_num", bout.cycle_num, `TG_NUM_NONE);
        check_val("clken_n", bout.clken_n, 1);
        check_val("abspos", abspos, `TG_ABS_INIT);
        check_val("clk4m", clk4m, 1);
        clk_prev = clk4m;
        last_chg = cycles;
        n_chg    = 0;
        repeat (48)
        begin
            @(negedge MCLK);
            if (clk4m != clk_prev)
            begin
                if (n_chg > 0)
                    check_val("clk4m half period", cycles - last_chg, 6);
                n_chg++;
                last_chg = cycles;
                clk_prev = clk4m;
            end
        end
        if (n_chg < 7)
        begin
            $display("clk4m toggled only %0d times in 48 cycles", n_chg);
            other_errs++;
        end

        for (int i = 0; i < NSTEP; i++)
        begin
            @(posedge MCLK);
            en_n    <= steps[i].en_n;
            ctrl_in <= steps[i].ctrl;
            repeat (10) @(posedge MCLK);
            @(negedge MCLK);
            check_val("acc_type", acc_type, steps[i].exp);
        end

        // page read, two pulses in seek so a +Y clears the counters
        set_ctrl(1'b0, 4'b0111, STBY);
        set_ctrl(1'b0, 4'b1101, IDLE);
        have_prev = 1'b0;
        take_pulse(num);
        take_pulse(num);
        set_ctrl(1'b0, 4'b1100, USER);
        skip_empty(num);
        for (int b = 0; b <= `TG_PAGE_LAST; b++)
        begin
            if (b > 0)
                take_pulse(num);
            check_val("cycle_num", num, b);
        end
        repeat (5)
        begin
            take_pulse(num);
            check_val("cycle_num", num, `TG_PAGE_LAST);
        end

        // bootloop read from a stopped field
        set_ctrl(1'b0, 4'b1011, RST);
        repeat (2 * BUBBLE) @(posedge MCLK);
        set_ctrl(1'b0, 4'b0011, STBY);
        set_ctrl(1'b0, 4'b1001, BOOT);
        have_prev = 1'b0;
        skip_empty(num);
        if (num > `TG_BOOT_LAST)
            check_val("cycle_num", num, `TG_BOOT_LAST);
        for (int i = 1; i < 300; i++)
        begin
            exp_num = (num == `TG_BOOT_LAST) ? '0 : num + 1'b1;
            take_pulse(num);
            check_val("cycle_num", num, exp_num);
        end

        // disable, field coasts to -X and stops
        @(posedge MCLK);
        en_n <= 1'b1;
        repeat (BUBBLE) @(negedge MCLK);
        pos0  = abspos;
        stray = 0;
        repeat (2 * BUBBLE)
        begin
            @(negedge MCLK);
            if (!bout.clken_n)
                stray++;
        end
        if (stray != 0)
        begin
            $display("%0d clken_n pulses after the field should have stopped", stray);
            other_errs++;
        end
        check_val("acc_type", acc_type, RST);
        check_val("cycle_num", bout.cycle_num, `TG_NUM_NONE);
        check_val("abspos", abspos, pos0);

        $display("errors: %0d value, %0d other", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
rtl/tg_pkg.sv
rtl/clock_phase_gen.sv
rtl/access_decode.sv
rtl/field_rotation.sv
rtl/bout_cycle_result.sv
rtl/timing_generator.sv
tests/tg_props.sv
tests/tb_timing_generator.sv
